// File: src.f
+incdir+include
design/swarm_pkg.sv
design/slot_fifo.sv
design/locale_lock.sv
design/rw_read_stage.sv
design/rw_write_stage.sv
design/rw_data_array.sv
design/rw_unit_top.sv
tb/rw_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the rw_unit testbench with Verilator.
set -u
cd "$(dirname "$0")"

LOG=sim.log
BUILD_LOG=build.log

verilator --binary --timing -Wno-fatal --top-module rw_unit_tb \
   -f src.f --Mdir obj_dir -o rw_unit_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
   cat "$BUILD_LOG"
   echo "verilator build exited with status $status"
   exit 1
fi

./obj_dir/rw_unit_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Test failed" "$LOG"; then
   exit 1
fi
exit 0

// File: include/rw_tb_model.svh
`ifndef RW_TB_MODEL_SVH
`define RW_TB_MODEL_SVH

// ----------------------------------------
// reference model, one 32-bit word per slot
// ----------------------------------------
logic [31:0]          model_mem [256];
logic [31:0]          model_base;
task_in_t             exp_fwd [$];   // tasks expected on task_out, in order.
logic [CQ_SLOT_W-1:0] exp_fin [$];   // slots expected on finish_slot, in order.

function automatic void model_reset();
   for (int i = 0; i < 256; i++) model_mem[i] = '1;  // infinite distance.
   model_base = '0;
   exp_fwd.delete();
   exp_fin.delete();
endfunction

// base register keeps only word-aligned addresses.
function automatic void model_set_base(input logic [31:0] wdata);
   model_base = {wdata[31:2], 2'b00};
endfunction

function automatic logic [7:0] model_word(input logic [LOCALE_W-1:0] locale);
   logic [31:0] idx;
   idx = (model_base >> 2) + 32'(locale);
   return idx[7:0];  // 16 lines of 16 words wrap here.
endfunction

// relaxation rule, applied in admission order.
function automatic void model_apply(input task_in_t t);
   logic [7:0] w;
   w = model_word(t.task_desc.locale);
   if (model_mem[w] > t.task_desc.ts) begin
      model_mem[w] = t.task_desc.ts;
      exp_fwd.push_back(t);
   end else begin
      exp_fin.push_back(t.cq_slot);
   end
endfunction

`endif

// File: tb/rw_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rw_unit_tb;

   import swarm_pkg::*;

   localparam int SEED          = 75380;
   localparam int HS_TIMEOUT    = 200;  // cycles allowed for one input handshake.
   localparam int DRAIN_TIMEOUT = 3000;

   logic                   clk;
   logic                   rstn;
   logic                   task_in_valid;
   logic                   task_in_ready;
   task_in_t               task_in;
   logic                   task_out_valid;
   logic                   task_out_ready;
   task_desc_t             task_out;
   logic [CQ_SLOT_W-1:0]   task_out_cq_slot;
   logic                   finish_valid;
   logic                   finish_ready;
   logic [CQ_SLOT_W-1:0]   finish_slot;
   logic [FIFO_SIZE_W-1:0] task_out_fifo_occ;
   reg_wr_t                reg_wr;

   string                cur_test;
   int                   errors, checks, tests_run, test_errors0, fwd_seen;
   bit                   timed_out, rand_ready, fwd_held, fin_held;
   logic [CQ_SLOT_W-1:0] next_slot, fin_last, fin_exp;
   task_in_t             fwd_act, fwd_last, fwd_exp;

   `include "rw_tb_model.svh"

   rw_unit_top #(.NUM_THREADS(4), .LOG_LINES(4), .LOG_DEPTH(1)) dut_i (
      .clk (clk), .rstn (rstn),
      .task_in_valid (task_in_valid), .task_in_ready (task_in_ready), .task_in (task_in),
      .task_out_valid (task_out_valid), .task_out_ready (task_out_ready),
      .task_out (task_out), .task_out_cq_slot (task_out_cq_slot),
      .finish_valid (finish_valid), .finish_ready (finish_ready), .finish_slot (finish_slot),
      .task_out_fifo_occ (task_out_fifo_occ), .reg_wr (reg_wr)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(negedge clk) begin
      task_out_ready = rand_ready ? ($urandom_range(3, 0) != 0) : 1'b1;
      finish_ready   = rand_ready ? ($urandom_range(1, 0) != 0) : 1'b1;
   end

   // ----------------------------------------
   // output monitor
   // ----------------------------------------
   always @(posedge clk) begin
      if (!rstn) begin
         fwd_held = 1'b0;
         fin_held = 1'b0;
      end else begin
         fwd_act = {task_out, task_out_cq_slot};
         if (fwd_held) begin
            checks++;
            if (!task_out_valid || fwd_act != fwd_last) begin
               errors++;
               $display("[FAIL] %s: stalled task_out expected %h actual %h (valid %0b)",
                        cur_test, fwd_last, fwd_act, task_out_valid);
            end
         end
         if (fin_held) begin
            checks++;
            if (!finish_valid || finish_slot != fin_last) begin
               errors++;
               $display("[FAIL] %s: stalled finish_slot expected %h actual %h (valid %0b)",
                        cur_test, fin_last, finish_slot, finish_valid);
            end
         end
         if (task_out_valid && task_out_ready) begin
            fwd_seen++;
            if (exp_fwd.size() == 0) begin
               errors++;
               $display("ERROR %s: task_out %h came out with no task left to forward",
                        cur_test, fwd_act);
            end else begin
               fwd_exp = exp_fwd.pop_front();
               checks++;
               if (fwd_act != fwd_exp) begin
                  errors++;
                  $display("[FAIL] %s: task_out expected %h actual %h",
                           cur_test, fwd_exp, fwd_act);
               end
            end
         end
         if (finish_valid && finish_ready) begin
            if (exp_fin.size() == 0) begin
               errors++;
               $display("ERROR %s: finish slot %h came out with no task left to finish",
                        cur_test, finish_slot);
            end else begin
               fin_exp = exp_fin.pop_front();
               checks++;
               if (finish_slot != fin_exp) begin
                  errors++;
                  $display("[FAIL] %s: finish_slot expected %h actual %h",
                           cur_test, fin_exp, finish_slot);
               end
            end
         end
         fwd_held = task_out_valid && !task_out_ready;
         fwd_last = fwd_act;
         fin_held = finish_valid && !finish_ready;
         fin_last = finish_slot;
      end
   end

   // ----------------------------------------
   // stimulus tasks
   // ----------------------------------------
   task automatic send_task(input logic [LOCALE_W-1:0] locale, input logic [TS_W-1:0] ts);
      task_in_t t;
      int       waited;
      bit       done;
      t.task_desc.locale = locale;
      t.task_desc.ts     = ts;
      t.cq_slot          = next_slot;
      next_slot++;
      waited = 0;
      done   = 1'b0;
      @(negedge clk);
      task_in       = t;
      task_in_valid = 1'b1;
      while (!done && waited < HS_TIMEOUT) begin
         @(posedge clk);
         if (task_in_ready) begin
            done = 1'b1;
            model_apply(t);
         end else begin
            waited++;
         end
      end
      if (!done) begin
         errors++;
         timed_out = 1'b1;
         $display("ERROR %s: task input not accepted within %0d cycles", cur_test, HS_TIMEOUT);
      end
   endtask

   task automatic send_random(input int count, input int lo, input int hi, input int ts_max);
      for (int i = 0; i < count && !timed_out; i++) begin
         send_task(LOCALE_W'($urandom_range(hi, lo)), TS_W'($urandom_range(ts_max, 0)));
      end
      @(negedge clk);
      task_in_valid = 1'b0;
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      @(negedge clk);
      reg_wr.wvalid = 1'b1;
      reg_wr.waddr  = addr;
      reg_wr.wdata  = data;
      @(negedge clk);
      reg_wr.wvalid = 1'b0;
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while ((exp_fwd.size() != 0 || exp_fin.size() != 0) && waited < DRAIN_TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      if (exp_fwd.size() != 0 || exp_fin.size() != 0) begin
         errors++;
         timed_out = 1'b1;
         $display("ERROR %s: %0d forwards and %0d finishes still missing after %0d cycles",
                  cur_test, exp_fwd.size(), exp_fin.size(), DRAIN_TIMEOUT);
      end
      repeat (10) @(negedge clk);  // room for a stray extra output.
   endtask

   task automatic start_test(input string name);
      cur_test     = name;
      test_errors0 = errors;
      fwd_seen     = 0;
   endtask

   task automatic finish_test();
      tests_run++;
      if (errors == test_errors0) $display("[DONE] %s ok", cur_test);
      else $display("[DONE] %s with %0d errors", cur_test, errors - test_errors0);
   endtask

   // ----------------------------------------
   // test sequence
   // ----------------------------------------
   initial begin
      void'($urandom(SEED));
      rstn              = 1'b0;
      task_in_valid     = 1'b0;
      task_in           = '0;
      task_out_ready    = 1'b1;
      finish_ready      = 1'b1;
      task_out_fifo_occ = '0;
      reg_wr            = '0;
      errors            = 0;
      checks            = 0;
      tests_run         = 0;
      timed_out         = 1'b0;
      rand_ready        = 1'b0;
      next_slot         = '0;
      model_reset();
      repeat (2) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;

      start_test("relax_basic");
      send_random(60, 0, 7, 1000);
      wait_drain();
      finish_test();

      if (!timed_out) begin
         start_test("same_locale_burst");
         for (int i = 0; i < 8; i++) send_task(16'd12, 32'(5000 - 100 * i));
         for (int i = 0; i < 8; i++) send_task(16'd12, 32'(4300 + 100 * i));
         @(negedge clk);
         task_in_valid = 1'b0;
         wait_drain();
         checks++;
         if (fwd_seen != 8) begin
            errors++;
            $display("[FAIL] %s: forwards expected 8 actual %0d", cur_test, fwd_seen);
         end
         finish_test();
      end

      if (!timed_out) begin
         start_test("backpressure");
         @(posedge clk);
         rand_ready = 1'b1;
         send_random(80, 0, 15, 1500);
         wait_drain();
         @(posedge clk);
         rand_ready = 1'b0;
         finish_test();
      end

      if (!timed_out) begin
         start_test("occupancy_threshold");
         @(negedge clk);
         task_out_fifo_occ = 6'd10;
         write_reg(FIFO_OUT_THRESH, 32'd10);
         fork
            send_random(6, 0, 7, 1000);
            begin
               for (int i = 0; i < 50; i++) begin
                  @(negedge clk);
                  checks++;
                  if (task_out_valid || finish_valid) begin
                     errors++;
                     $display("ERROR %s: output came out while occupancy was at the threshold",
                              cur_test);
                  end
               end
               task_out_fifo_occ = 6'd3;
            end
         join
         wait_drain();
         task_out_fifo_occ = '0;
         finish_test();
      end

      if (!timed_out) begin
         start_test("base_address");
         write_reg(RW_BASE_ADDR, 32'h0000_0193);
         model_set_base(32'h0000_0193);
         send_random(40, 152, 163, 3000);  // words wrap past 255 onto the old ones.
         wait_drain();
         finish_test();
      end

      $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0 && !timed_out) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: design/rw_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module rw_unit_top #(
   parameter int NUM_THREADS = 4,
   parameter int LOG_LINES   = 4,
   parameter int LOG_DEPTH   = 1
) (
   input  logic                                 clk,
   input  logic                                 rstn,
   input  logic                                 task_in_valid,
   output logic                                 task_in_ready,
   input  swarm_pkg::task_in_t                  task_in,
   output logic                                 task_out_valid,
   input  logic                                 task_out_ready,
   output swarm_pkg::task_desc_t                task_out,
   output logic [swarm_pkg::CQ_SLOT_W-1:0]      task_out_cq_slot,
   output logic                                 finish_valid,
   input  logic                                 finish_ready,
   output logic [swarm_pkg::CQ_SLOT_W-1:0]      finish_slot,
   input  logic [swarm_pkg::FIFO_SIZE_W-1:0]    task_out_fifo_occ,
   input  swarm_pkg::reg_wr_t                   reg_wr
);

   import swarm_pkg::*;

   logic                lk_valid, lk_ready;
   rw_write_t           lk_rec;
   logic                rs_valid, rs_ready;
   rw_write_t           rs_rec;
   logic                rd_req;
   logic [ADDR_W-1:0]   rd_addr;
   logic [LINE_W-1:0]   rd_data;
   logic                wvalid, wready;
   logic [ADDR_W-1:0]   waddr;
   logic [LINE_W-1:0]   wdata;
   logic [STRB_W-1:0]   wstrb;
   logic                unlock;
   logic [THREAD_W-1:0] unlock_thread;
   logic [ADDR_W-1:0]   base_addr;

   locale_lock #(.NUM_THREADS(NUM_THREADS)) lock_i (
      .clk (clk), .rstn (rstn),
      .in_valid (task_in_valid), .in_ready (task_in_ready), .in_task (task_in),
      .out_valid (lk_valid), .out_ready (lk_ready), .out_task (lk_rec),
      .unlock (unlock), .unlock_thread (unlock_thread)
   );

   rw_read_stage read_i (
      .clk (clk), .rstn (rstn),
      .in_valid (lk_valid), .in_ready (lk_ready), .in_rec (lk_rec),
      .base_addr (base_addr),
      .rd_req (rd_req), .rd_addr (rd_addr), .rd_data (rd_data),
      .out_valid (rs_valid), .out_ready (rs_ready), .out_rec (rs_rec)
   );

   rw_write_stage #(.LOG_DEPTH(LOG_DEPTH)) write_i (
      .clk (clk), .rstn (rstn),
      .task_in_valid (rs_valid), .task_in_ready (rs_ready), .task_in (rs_rec),
      .wvalid (wvalid), .wready (wready), .waddr (waddr), .wdata (wdata), .wstrb (wstrb),
      .task_out_valid (task_out_valid), .task_out_ready (task_out_ready),
      .task_out (task_out), .task_out_cq_slot (task_out_cq_slot),
      .task_out_fifo_occ (task_out_fifo_occ),
      .unlock_locale (unlock), .unlock_thread (unlock_thread),
      .finish_valid (finish_valid), .finish_ready (finish_ready),
      .finish_slot (finish_slot),
      .reg_wr (reg_wr), .base_addr (base_addr)
   );

   rw_data_array #(.LOG_LINES(LOG_LINES)) array_i (
      .clk (clk), .rstn (rstn),
      .rd_req (rd_req), .rd_addr (rd_addr), .rd_data (rd_data),
      .wvalid (wvalid), .wready (wready), .waddr (waddr), .wdata (wdata), .wstrb (wstrb)
   );

endmodule

`default_nettype wire

// File: design/rw_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module rw_data_array #(
   parameter int LOG_LINES = 4
) (
   input  logic                            clk,
   input  logic                            rstn,
   input  logic                            rd_req,
   input  logic [swarm_pkg::ADDR_W-1:0]    rd_addr,
   output logic [swarm_pkg::LINE_W-1:0]    rd_data,
   input  logic                            wvalid,
   output logic                            wready,
   input  logic [swarm_pkg::ADDR_W-1:0]    waddr,
   input  logic [swarm_pkg::LINE_W-1:0]    wdata,
   input  logic [swarm_pkg::STRB_W-1:0]    wstrb
);

   import swarm_pkg::*;

   localparam int NUM_LINES = 2 ** LOG_LINES;

   logic [LINE_W-1:0]    mem [NUM_LINES];
   logic [LOG_LINES-1:0] rd_line;
   logic [LOG_LINES-1:0] wr_line;

   // byte address wraps on the array size.
   assign rd_line = rd_addr[LINE_OFF_W +: LOG_LINES];
   assign wr_line = waddr[LINE_OFF_W +: LOG_LINES];

   // single port, reads win.
   assign wready = !rd_req;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < NUM_LINES; i++) mem[i] <= '1;  // infinite distance.
      end else if (wvalid && wready) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (wstrb[b]) mem[wr_line][b * 8 +: 8] <= wdata[b * 8 +: 8];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rd_req) rd_data <= mem[rd_line];
   end

   // base address and locale shift must keep reads on a word boundary.
   a_rd_aligned : assert property (@(posedge clk) disable iff (!rstn)
      rd_req |-> (rd_addr[1:0] == 2'b00));

endmodule

`default_nettype wire

// File: design/rw_write_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rw_write_stage #(
   parameter int LOG_DEPTH = 1
) (
   input  logic                                 clk,
   input  logic                                 rstn,
   input  logic                                 task_in_valid,
   output logic                                 task_in_ready,
   input  swarm_pkg::rw_write_t                 task_in,
   output logic                                 wvalid,
   input  logic                                 wready,
   output logic [swarm_pkg::ADDR_W-1:0]         waddr,
   output logic [swarm_pkg::LINE_W-1:0]         wdata,
   output logic [swarm_pkg::STRB_W-1:0]         wstrb,
   output logic                                 task_out_valid,
   input  logic                                 task_out_ready,
   output swarm_pkg::task_desc_t                task_out,
   output logic [swarm_pkg::CQ_SLOT_W-1:0]      task_out_cq_slot,
   input  logic [swarm_pkg::FIFO_SIZE_W-1:0]    task_out_fifo_occ,
   output logic                                 unlock_locale,
   output logic [swarm_pkg::THREAD_W-1:0]       unlock_thread,
   output logic                                 finish_valid,
   input  logic                                 finish_ready,
   output logic [swarm_pkg::CQ_SLOT_W-1:0]      finish_slot,
   input  swarm_pkg::reg_wr_t                   reg_wr,
   output logic [swarm_pkg::ADDR_W-1:0]         base_addr
);

   import swarm_pkg::*;

   logic [FIFO_SIZE_W-1:0] out_thresh;
   logic                   fin_push_valid;
   logic                   fin_full;
   logic                   fin_empty;
   logic [WORD_SEL_W-1:0]  widx;

   // ----------------------------------------
   // compare and dispatch
   // ----------------------------------------
   assign waddr = base_addr
                + {{(ADDR_W - LOCALE_W - 2){1'b0}}, task_in.task_desc.locale, 2'b00};
   assign widx  = waddr[LINE_OFF_W-1:2];
   assign wdata = {(LINE_W / TS_W){task_in.task_desc.ts}};  // strobe picks the word.

   always_comb begin
      wvalid         = 1'b0;
      wstrb          = '0;
      task_in_ready  = 1'b0;
      fin_push_valid = 1'b0;
      wstrb[widx * 4 +: 4] = 4'hf;
      if (task_in_valid && (task_out_fifo_occ < out_thresh)) begin
         if (task_in.object > task_in.task_desc.ts) begin
            // a shorter distance is stored and the task passed on.
            wvalid        = !task_out_valid || task_out_ready;
            task_in_ready = wvalid && wready;
         end else begin
            fin_push_valid = 1'b1;
            task_in_ready  = !fin_full;
         end
      end
   end

   assign unlock_locale = task_in_valid && task_in_ready;
   assign unlock_thread = task_in.thread;

   // ----------------------------------------
   // forward path
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (!rstn) begin
         task_out_valid <= 1'b0;
      end else begin
         if (wvalid && wready) task_out_valid <= 1'b1;
         else if (task_out_ready) task_out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (wvalid && wready) begin
         task_out         <= task_in.task_desc;
         task_out_cq_slot <= task_in.cq_slot;
      end
   end

   // ----------------------------------------
   // finish path
   // ----------------------------------------
   slot_fifo #(
      .WIDTH     (CQ_SLOT_W),
      .LOG_DEPTH (LOG_DEPTH)
   ) finish_fifo_i (
      .clk     (clk),
      .rstn    (rstn),
      .wr_en   (fin_push_valid && !fin_full),
      .wr_data (task_in.cq_slot),
      .rd_en   (finish_valid && finish_ready),
      .rd_data (finish_slot),
      .full    (fin_full),
      .empty   (fin_empty)
   );

   assign finish_valid = !fin_empty;

   // ----------------------------------------
   // config registers
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (!rstn) begin
         base_addr  <= '0;
         out_thresh <= '1;
      end else if (reg_wr.wvalid) begin
         case (reg_wr.waddr)
            RW_BASE_ADDR    : base_addr  <= {reg_wr.wdata[ADDR_W-1:2], 2'b00};
            FIFO_OUT_THRESH : out_thresh <= reg_wr.wdata[FIFO_SIZE_W-1:0];
            default         : ;
         endcase
      end
   end

   a_wvalid_task : assert property (@(posedge clk) disable iff (!rstn)
      wvalid |-> task_in_valid);

endmodule

`default_nettype wire

// File: design/rw_read_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rw_read_stage (
   input  logic                               clk,
   input  logic                               rstn,
   input  logic                               in_valid,
   output logic                               in_ready,
   input  swarm_pkg::rw_write_t               in_rec,
   input  logic [swarm_pkg::ADDR_W-1:0]       base_addr,
   output logic                               rd_req,
   output logic [swarm_pkg::ADDR_W-1:0]       rd_addr,
   input  logic [swarm_pkg::LINE_W-1:0]       rd_data,
   output logic                               out_valid,
   input  logic                               out_ready,
   output swarm_pkg::rw_write_t               out_rec
);

   import swarm_pkg::*;

   rd_state_e             state;
   rw_write_t             rd_rec;
   logic [WORD_SEL_W-1:0] rd_widx;
   rw_write_t             front_rec;
   logic                  front_go;

   // ----------------------------------------
   // request side
   // ----------------------------------------
   assign in_ready = (state == IDLE) || !out_valid;
   assign rd_req   = in_valid && in_ready;
   assign rd_addr  = base_addr
                   + {{(ADDR_W - LOCALE_W - 2){1'b0}}, in_rec.task_desc.locale, 2'b00};

   // front slot moves to the output register when that one frees up.
   assign front_go = (state != IDLE) && (!out_valid || out_ready);

   always_comb begin
      front_rec = rd_rec;
      if (state == READ) front_rec.object = rd_data[rd_widx * TS_W +: TS_W];
   end

   // ----------------------------------------
   // control
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (!rstn) begin
         state     <= IDLE;
         out_valid <= 1'b0;
      end else begin
         if (rd_req) state <= READ;
         else if (front_go) state <= IDLE;
         else if (state == READ) state <= HOLD;  // keep the word while the output is busy.

         if (front_go) out_valid <= 1'b1;
         else if (out_ready) out_valid <= 1'b0;
      end
   end

   // ----------------------------------------
   // payload
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (rd_req) begin
         rd_rec  <= in_rec;
         rd_widx <= rd_addr[LINE_OFF_W-1:2];
      end else if (state == READ) begin
         rd_rec.object <= rd_data[rd_widx * TS_W +: TS_W];
      end
      if (front_go) out_rec <= front_rec;
   end

endmodule

`default_nettype wire

// File: design/locale_lock.sv
`timescale 1ns/1ps
`default_nettype none

module locale_lock #(
   parameter int NUM_THREADS = 4
) (
   input  logic                             clk,
   input  logic                             rstn,
   input  logic                             in_valid,
   output logic                             in_ready,
   input  swarm_pkg::task_in_t              in_task,
   output logic                             out_valid,
   input  logic                             out_ready,
   output swarm_pkg::rw_write_t             out_task,
   input  logic                             unlock,
   input  logic [swarm_pkg::THREAD_W-1:0]   unlock_thread
);

   import swarm_pkg::*;

   logic                lock_valid  [NUM_THREADS];
   logic [LOCALE_W-1:0] lock_locale [NUM_THREADS];

   logic                hit;
   logic                have_free;
   logic [THREAD_W-1:0] free_idx;

   // lowest free entry, and whether the locale is already held.
   always_comb begin
      hit       = 1'b0;
      have_free = 1'b0;
      free_idx  = '0;
      for (int i = NUM_THREADS - 1; i >= 0; i--) begin
         if (!lock_valid[i]) begin
            have_free = 1'b1;
            free_idx  = THREAD_W'(i);
         end
         if (lock_valid[i] && (lock_locale[i] == in_task.task_desc.locale)) hit = 1'b1;
      end
   end

   assign out_valid          = in_valid && !hit && have_free;
   assign in_ready           = out_ready && !hit && have_free;
   assign out_task.task_desc = in_task.task_desc;
   assign out_task.cq_slot   = in_task.cq_slot;
   assign out_task.object    = '0;  // filled by the read stage.
   assign out_task.thread    = free_idx;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < NUM_THREADS; i++) lock_valid[i] <= 1'b0;
      end else begin
         if (in_valid && in_ready) lock_valid[free_idx] <= 1'b1;
         if (unlock) lock_valid[unlock_thread] <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && in_ready) lock_locale[free_idx] <= in_task.task_desc.locale;
   end

   // the write stage only releases threads that this table handed out.
   a_unlock_held : assert property (@(posedge clk) disable iff (!rstn)
      unlock |-> lock_valid[unlock_thread]);

endmodule

`default_nettype wire

// File: design/slot_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module slot_fifo #(
   parameter int WIDTH     = 6,
   parameter int LOG_DEPTH = 1
) (
   input  logic             clk,
   input  logic             rstn,
   input  logic             wr_en,
   input  logic [WIDTH-1:0] wr_data,
   input  logic             rd_en,
   output logic [WIDTH-1:0] rd_data,
   output logic             full,
   output logic             empty
);

   localparam int DEPTH = 2 ** LOG_DEPTH;

   logic [WIDTH-1:0] mem [DEPTH];
   logic [LOG_DEPTH:0] wr_ptr;  // extra msb tells full from empty.
   logic [LOG_DEPTH:0] rd_ptr;

   assign empty   = (wr_ptr == rd_ptr);
   assign full    = (wr_ptr == {~rd_ptr[LOG_DEPTH], rd_ptr[LOG_DEPTH-1:0]});
   assign rd_data = mem[rd_ptr[LOG_DEPTH-1:0]];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en) wr_ptr <= wr_ptr + 1'b1;
         if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) mem[wr_ptr[LOG_DEPTH-1:0]] <= wr_data;
   end

   a_no_overflow : assert property (@(posedge clk) disable iff (!rstn) wr_en |-> !full);
   a_no_underflow : assert property (@(posedge clk) disable iff (!rstn) rd_en |-> !empty);

endmodule

`default_nettype wire

// File: design/swarm_pkg.sv
`default_nettype none

package swarm_pkg;

   // ----------------------------------------
   // widths
   // ----------------------------------------
   localparam int LOCALE_W    = 16;
   localparam int TS_W        = 32;
   localparam int CQ_SLOT_W   = 6;
   localparam int THREAD_W    = 2;  // enough for the default 4 threads.
   localparam int FIFO_SIZE_W = 6;

   localparam int ADDR_W      = 32;
   localparam int LINE_W      = 512;
   localparam int STRB_W      = LINE_W / 8;
   localparam int LINE_OFF_W  = $clog2(STRB_W);       // byte offset inside a line.
   localparam int WORD_SEL_W  = $clog2(LINE_W / TS_W); // word index inside a line.

   // ----------------------------------------
   // task records
   // ----------------------------------------
   typedef struct packed {
      logic [LOCALE_W-1:0] locale;
      logic [TS_W-1:0]     ts;
   } task_desc_t;

   typedef struct packed {
      task_desc_t           task_desc;
      logic [CQ_SLOT_W-1:0] cq_slot;
   } task_in_t;

   // object carries the stored value once the read stage has fetched it.
   typedef struct packed {
      task_desc_t           task_desc;
      logic [CQ_SLOT_W-1:0] cq_slot;
      logic [TS_W-1:0]      object;
      logic [THREAD_W-1:0]  thread;
   } rw_write_t;

   // ----------------------------------------
   // register bus and encodings
   // ----------------------------------------
   typedef struct packed {
      logic        wvalid;
      logic [7:0]  waddr;
      logic [31:0] wdata;
   } reg_wr_t;

   typedef enum logic [7:0] {
      RW_BASE_ADDR    = 8'h00,
      FIFO_OUT_THRESH = 8'h04
   } rw_reg_e;

   typedef enum logic [1:0] {
      IDLE,
      READ,
      HOLD
   } rd_state_e;

endpackage

`default_nettype wire
